// File: hdl/rvm_cfg.svh
`ifndef RVM_CFG_SVH
`define RVM_CFG_SVH

// Data path width
`define RVM_WORD_SIZE 32

// Destination register address width
`define RVM_REG_ADDR_SIZE 5

// Total latency in cycles, 2 or more
// Paths take one stage, the result pipeline the rest
`define RVM_STAGES 5

`endif

// File: hdl/rvm_pkg.sv
`default_nettype none

`include "rvm_cfg.svh"

package rvm_pkg;

    typedef logic [`RVM_WORD_SIZE-1:0]   word_t;
    typedef logic [2*`RVM_WORD_SIZE-1:0] dword_t;
    typedef logic [`RVM_REG_ADDR_SIZE-1:0] reg_addr_t;

    // Top bit selects the divide group
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } rvm_op_e;

    typedef struct packed {
        rvm_op_e   op;
        word_t     src_a;
        word_t     src_b;
        logic      rf_we;
        reg_addr_t rf_waddr;
    } rvm_req_t;

    typedef struct packed {
        word_t     result;
        logic      rf_we;
        reg_addr_t rf_waddr;
    } rvm_wb_t;

    function automatic logic op_is_div(rvm_op_e op);
        return op[2];
    endfunction

endpackage

`default_nettype wire

// File: hdl/rvm_mul.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvm_cfg.svh"

module rvm_mul
    import rvm_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    input  rvm_op_e op_i,
    input  word_t   src_a_i,
    input  word_t   src_b_i,

    output word_t   mul_res_o
);

    localparam int W = `RVM_WORD_SIZE;

    dword_t prod_ss;
    dword_t prod_uu;
    dword_t prod_su;
    word_t  mul_sel;

    // Double width products, extended in the 64-bit context
    always_comb begin
        prod_ss = $signed(src_a_i) * $signed(src_b_i);
        prod_uu = src_a_i * src_b_i;
        // Zero sign bit keeps src_b unsigned
        prod_su = $signed(src_a_i) * $signed({1'b0, src_b_i});
    end

    always_comb begin
        case (op_i)
            OP_MUL: begin
                mul_sel = prod_ss[W-1:0];
            end
            OP_MULH: begin
                mul_sel = prod_ss[2*W-1:W];
            end
            OP_MULHSU: begin
                mul_sel = prod_su[2*W-1:W];
            end
            OP_MULHU: begin
                mul_sel = prod_uu[2*W-1:W];
            end
            default: begin
                // Divide group, dropped by the result pipeline
                mul_sel = prod_uu[W-1:0];
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_res_o <= '0;
        end else begin
            mul_res_o <= mul_sel;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rvm_div.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvm_cfg.svh"

module rvm_div
    import rvm_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    input  rvm_op_e op_i,
    input  word_t   src_a_i,
    input  word_t   src_b_i,

    output word_t   div_res_o
);

    localparam word_t MOST_NEG = {1'b1, {(`RVM_WORD_SIZE-1){1'b0}}};
    localparam word_t ALL_ONES = '1;
    localparam word_t ONE      = word_t'(1);

    logic  div_by_zero;
    logic  overflow;
    word_t divisor_s;
    word_t divisor_u;
    word_t quot_s;
    word_t rem_s;
    word_t quot_u;
    word_t rem_u;
    word_t div_sel;

    always_comb begin
        div_by_zero = (src_b_i == '0);
        overflow    = (src_a_i == MOST_NEG) && (src_b_i == ALL_ONES);
    end

    // Safe divisors so the dividers never see the special cases
    // A divisor of one on overflow yields the dividend and a zero remainder
    always_comb begin
        divisor_s = (div_by_zero || overflow) ? ONE : src_b_i;
        divisor_u = div_by_zero ? ONE : src_b_i;
    end

    // Truncating division with the remainder taking the dividend sign
    always_comb begin
        quot_s = $signed(src_a_i) / $signed(divisor_s);
        rem_s  = $signed(src_a_i) % $signed(divisor_s);
        quot_u = src_a_i / divisor_u;
        rem_u  = src_a_i % divisor_u;
    end

    always_comb begin
        case (op_i)
            OP_DIV: begin
                div_sel = div_by_zero ? ALL_ONES : quot_s;
            end
            OP_DIVU: begin
                div_sel = div_by_zero ? ALL_ONES : quot_u;
            end
            OP_REM: begin
                div_sel = div_by_zero ? src_a_i : rem_s;
            end
            OP_REMU: begin
                div_sel = div_by_zero ? src_a_i : rem_u;
            end
            default: begin
                // Multiply group
                div_sel = quot_u;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            div_res_o <= '0;
        end else begin
            div_res_o <= div_sel;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rvm_result_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvm_cfg.svh"

module rvm_result_pipe
    import rvm_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,

    input  rvm_req_t req_i,
    input  word_t    mul_res_i,
    input  word_t    div_res_i,

    output rvm_wb_t  wb_o
);

    // Stages left after the path registers
    localparam int WB_STAGES = `RVM_STAGES - 1;

    logic      div_grp_q;
    logic      rf_we_q;
    reg_addr_t rf_waddr_q;

    rvm_wb_t   wb_d;
    rvm_wb_t   wb_q [WB_STAGES];

    // Tag stage, in step with the path registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            div_grp_q  <= 1'b0;
            rf_we_q    <= 1'b0;
            rf_waddr_q <= '0;
        end else begin
            div_grp_q  <= op_is_div(req_i.op);
            rf_we_q    <= req_i.rf_we;
            rf_waddr_q <= req_i.rf_waddr;
        end
    end

    // Pick the path that owns this operation
    always_comb begin
        wb_d.result   = div_grp_q ? div_res_i : mul_res_i;
        wb_d.rf_we    = rf_we_q;
        wb_d.rf_waddr = rf_waddr_q;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < WB_STAGES; i++) begin
                wb_q[i] <= '0;
            end
        end else begin
            wb_q[0] <= wb_d;
            for (int i = 1; i < WB_STAGES; i++) begin
                wb_q[i] <= wb_q[i-1];
            end
        end
    end

    assign wb_o = wb_q[WB_STAGES-1];

endmodule

`default_nettype wire

// File: hdl/rvm_unit.sv
`timescale 1ns/100ps
`default_nettype none

module rvm_unit
    import rvm_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // Operation
    input  rvm_op_e   alu_opcode_i,
    input  word_t     alu_src_a_i,
    input  word_t     alu_src_b_i,
    // Writeback tag
    input  logic      rf_we_i,
    input  reg_addr_t rf_waddr_i,

    output word_t     alu_res_o,
    output logic      rf_we_o,
    output reg_addr_t rf_waddr_o
);

    rvm_req_t req;
    word_t    mul_res;
    word_t    div_res;
    rvm_wb_t  wb;

    assign req.op       = alu_opcode_i;
    assign req.src_a    = alu_src_a_i;
    assign req.src_b    = alu_src_b_i;
    assign req.rf_we    = rf_we_i;
    assign req.rf_waddr = rf_waddr_i;

    rvm_mul i_mul (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .op_i      (req.op),
        .src_a_i   (req.src_a),
        .src_b_i   (req.src_b),
        .mul_res_o (mul_res)
    );

    rvm_div i_div (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .op_i      (req.op),
        .src_a_i   (req.src_a),
        .src_b_i   (req.src_b),
        .div_res_o (div_res)
    );

    rvm_result_pipe i_result_pipe (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (req),
        .mul_res_i (mul_res),
        .div_res_i (div_res),
        .wb_o      (wb)
    );

    assign alu_res_o  = wb.result;
    assign rf_we_o    = wb.rf_we;
    assign rf_waddr_o = wb.rf_waddr;

endmodule

`default_nettype wire

// File: tests/rvm_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module rvm_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // High for two rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/rvm_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rvm_cfg.svh"

module rvm_unit_tb
    import rvm_pkg::*;
();

    localparam int STAGES  = `RVM_STAGES;
    localparam int MAX_OPS = 64;

    logic      clk;
    logic      rst;
    rvm_op_e   alu_opcode;
    word_t     alu_src_a;
    word_t     alu_src_b;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     dut_res;
    logic      dut_we;
    reg_addr_t dut_waddr;

    // Golden operations
    string      gold_name [MAX_OPS];
    logic [2:0] gold_op   [MAX_OPS];
    word_t      gold_a    [MAX_OPS];
    word_t      gold_b    [MAX_OPS];
    logic       gold_we   [MAX_OPS];
    reg_addr_t  gold_addr [MAX_OPS];
    word_t      gold_res  [MAX_OPS];
    int         num_ops;

    // Golden index per cycle in flight, -1 for a bubble
    int     pend_q [$];
    int     errors;
    int     checks;
    integer seed;
    int     cycle_cnt;
    int     cycle_limit;
    logic   limit_set;

    rvm_clk_gen i_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    rvm_unit i_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .alu_opcode_i (alu_opcode),
        .alu_src_a_i  (alu_src_a),
        .alu_src_b_i  (alu_src_b),
        .rf_we_i      (rf_we),
        .rf_waddr_i   (rf_waddr),
        .alu_res_o    (dut_res),
        .rf_we_o      (dut_we),
        .rf_waddr_o   (dut_waddr)
    );

    task automatic read_golden(output logic ok);
        int         fd;
        int         n;
        string      line;
        string      name;
        logic [2:0] op;
        word_t      a;
        word_t      b;
        logic       we;
        reg_addr_t  addr;
        word_t      res;
        ok = 1'b0;
        num_ops = 0;
        fd = $fopen("tests/rvm_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file tests/rvm_golden.txt");
        end else begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                n = 0;
                // Lines starting with # are comments
                if (line.len() > 0 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h",
                                name, op, a, b, we, addr, res);
                end
                if (n == 7 && num_ops < MAX_OPS) begin
                    gold_name[num_ops] = name;
                    gold_op[num_ops]   = op;
                    gold_a[num_ops]    = a;
                    gold_b[num_ops]    = b;
                    gold_we[num_ops]   = we;
                    gold_addr[num_ops] = addr;
                    gold_res[num_ops]  = res;
                    num_ops++;
                end else if (n > 0) begin
                    $display("Golden line could not be read or does not fit: %s", line);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
            if (num_ops == 0) begin
                $display("The golden file holds no operations");
                ok = 1'b0;
            end
        end
    endtask

    task automatic drive_golden(input int idx);
        alu_opcode = rvm_op_e'(gold_op[idx]);
        alu_src_a  = gold_a[idx];
        alu_src_b  = gold_b[idx];
        rf_we      = gold_we[idx];
        rf_waddr   = gold_addr[idx];
    endtask

    task automatic drive_bubble();
        logic [2:0] op;
        op = 3'($random(seed));
        alu_opcode = rvm_op_e'(op);
        alu_src_a  = $random(seed);
        alu_src_b  = $random(seed);
        rf_we      = 1'b0;
        rf_waddr   = reg_addr_t'($random(seed));
    endtask

    task automatic check_outputs();
        int idx;
        if (pend_q.size() < STAGES) begin
            // First operation not out yet
            checks++;
            assert (dut_we === 1'b0 && dut_res === '0) else begin
                $display("mismatch reset_idle expected we 0 res %h actual we %b res %h",
                         word_t'(0), dut_we, dut_res);
                errors++;
            end
        end else begin
            idx = pend_q.pop_front();
            checks++;
            if (idx < 0) begin
                assert (dut_we === 1'b0) else begin
                    $display("mismatch bubble rf_we expected 0 actual %b", dut_we);
                    errors++;
                end
            end else begin
                assert (dut_res === gold_res[idx]) else begin
                    $display("mismatch %s result expected %h actual %h",
                             gold_name[idx], gold_res[idx], dut_res);
                    errors++;
                end
                assert (dut_we === gold_we[idx]) else begin
                    $display("mismatch %s rf_we expected %b actual %b",
                             gold_name[idx], gold_we[idx], dut_we);
                    errors++;
                end
                assert (dut_waddr === gold_addr[idx]) else begin
                    $display("mismatch %s rf_waddr expected %h actual %h",
                             gold_name[idx], gold_addr[idx], dut_waddr);
                    errors++;
                end
            end
        end
    endtask

    // One cycle: check what is due, then drive the next slot
    task automatic next_cycle(input int idx);
        @(negedge clk);
        check_outputs();
        if (idx >= 0) begin
            drive_golden(idx);
        end else begin
            drive_bubble();
        end
        pend_q.push_back(idx);
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        logic ok;
        errors     = 0;
        checks     = 0;
        seed       = 26;
        limit_set  = 1'b0;
        alu_opcode = OP_MUL;
        alu_src_a  = '0;
        alu_src_b  = '0;
        rf_we      = 1'b0;
        rf_waddr   = '0;
        read_golden(ok);
        if (!ok) begin
            errors++;
            finish_run();
        end else begin
            cycle_limit = num_ops * 2 + STAGES + 20;
            limit_set   = 1'b1;
            do begin
                @(negedge clk);
            end while (rst);
            for (int i = 0; i < num_ops; i++) begin
                if (($random(seed) & 3) == 0) begin
                    next_cycle(-1);
                end
                next_cycle(i);
            end
            // Flush the last operations out
            repeat (STAGES) next_cycle(-1);
            finish_run();
        end
    end

    initial begin
        cycle_cnt = 0;
        wait (limit_set === 1'b1);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
        errors++;
        finish_run();
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/rvm_pkg.sv
hdl/rvm_mul.sv
hdl/rvm_div.sv
hdl/rvm_result_pipe.sv
hdl/rvm_unit.sv
tests/rvm_clk_gen.sv
tests/rvm_unit_tb.sv

// File: tests/rvm_golden.txt
# name op src_a src_b rf_we rf_waddr expected, all but the name in hex
# op: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 DIV, 5 DIVU, 6 REM, 7 REMU
mul_small       0 00000007 00000006 1 01 0000002a
mul_neg         0 fffffffd 00000005 1 02 fffffff1
mul_zero        0 12345678 00000000 1 03 00000000
mul_minus_one   0 ffffffff ffffffff 1 04 00000001
mulh_mixed      1 fffffffd 00000005 1 05 ffffffff
mulh_most_neg   1 80000000 80000000 1 06 40000000
mulh_max_pos    1 7fffffff 7fffffff 1 07 3fffffff
mulh_minus_one  1 ffffffff ffffffff 0 08 00000000
mulhu_max       3 ffffffff ffffffff 1 09 fffffffe
mulhu_carry     3 80000000 00000002 1 0a 00000001
mulhu_zero      3 ffffffff 00000000 1 0b 00000000
mulhsu_neg      2 ffffffff ffffffff 1 0c ffffffff
mulhsu_pos      2 00000002 ffffffff 1 0d 00000001
mulhsu_most_neg 2 80000000 80000000 1 0e c0000000
div_pos         4 00000014 00000003 1 0f 00000006
div_neg_pos     4 ffffffec 00000003 1 10 fffffffa
div_pos_neg     4 00000014 fffffffd 1 11 fffffffa
div_neg_neg     4 ffffffec fffffffd 1 12 00000006
divu_large      5 ffffffec 00000003 1 13 5555554e
divu_small      5 00000064 00000007 1 14 0000000e
rem_pos         6 00000014 00000003 1 15 00000002
rem_neg_pos     6 ffffffec 00000003 1 16 fffffffe
rem_pos_neg     6 00000014 fffffffd 1 17 00000002
rem_neg_neg     6 ffffffec fffffffd 1 18 fffffffe
remu_large      7 ffffffec 00000003 1 19 00000002
remu_small      7 00000064 00000007 1 1a 00000002
div_by_zero     4 00001234 00000000 1 1b ffffffff
divu_by_zero    5 80000000 00000000 1 1c ffffffff
rem_by_zero     6 fffffff0 00000000 1 1d fffffff0
remu_by_zero    7 12345678 00000000 1 1e 12345678
div_overflow    4 80000000 ffffffff 1 1f 80000000
rem_overflow    6 80000000 ffffffff 1 01 00000000
divu_most_neg   5 80000000 ffffffff 0 02 00000000
remu_most_neg   7 80000000 ffffffff 1 03 80000000
alt_mul         0 0000ffff 0000ffff 1 04 fffe0001
alt_divu        5 fffe0001 0000ffff 1 05 0000ffff
alt_mulhu       3 00010000 00010000 0 06 00000001
alt_rem         6 00000007 fffffffe 1 07 00000001
